/* include/gsm_cfg.svh */
//********************************************************************
// gsm switch configuration
// port count, grouping, cell width and queue sizing
//********************************************************************
`ifndef GSM_CFG_SVH
`define GSM_CFG_SVH

// ingress and egress port count
`define GSM_NPORT 4
// ingress ports per tile
`define GSM_GSIZE 2
// tiles, nport / gsize
`define GSM_NTILE 2
// bits per cell or header word
`define GSM_DWIDTH 8
// cells per queue, one queue per local ingress / egress pair
`define GSM_QDEPTH 4
`define GSM_QAWIDTH 2	// log2 of queue depth

`endif

/* hdl/gsm_pkg.sv */
//********************************************************************
// gsm switch types shared by the tiles and the egress stage
//********************************************************************
`include "gsm_cfg.svh"

package gsm_pkg;

	typedef logic [`GSM_DWIDTH-1:0] data_t;	// cell or header word
	typedef logic [`GSM_NPORT-1:0] port_mask_t;	// dest mask, req, grant

	// ingress port number, also the rr pointer
	typedef logic [1:0] port_idx_t;

	typedef logic [`GSM_QAWIDTH-1:0] qptr_t;	// rd / wr pointer
	typedef logic [`GSM_QAWIDTH:0] qcnt_t;	// fill level, 0 .. depth

	// per ingress port header state
	typedef enum logic {
		PORT_IDLE,	// no mask held, payloads dropped
		PORT_ARMED	// mask held
	} port_state_t;

endpackage

/* hdl/ingress_deser.sv */
//********************************************************************
// ingress deserializer
// serial pin into one parallel word per ingress port
//********************************************************************
`timescale 1ns/1ps
`include "gsm_cfg.svh"

module ingress_deser import gsm_pkg::*; (
	input  logic clk,
	input  logic clr,
	input  logic i_sdata,	// serial data, one bit per clk
	output data_t [`GSM_NPORT-1:0] o_words	// word per ingress port
);

	localparam int SWIDTH = `GSM_NPORT * `GSM_DWIDTH;

	logic [SWIDTH-1:0] sreg;	// first bit in drifts to the msb

	//********************************************************************
	// shift in
	//********************************************************************
	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			sreg <= '0;
		end else begin
			sreg <= {sreg[SWIDTH-2:0], i_sdata};
		end
	end

	// slice per port
	// the tile samples at its strobe edge, so it sees
	// the value from before that edge's shift
	always_comb begin
		for (int p = 0; p < `GSM_NPORT; p++) begin
			o_words[p] = sreg[p*`GSM_DWIDTH +: `GSM_DWIDTH];	// port p at bit p*8
		end
	end

endmodule

/* hdl/gsm_tile.sv */
//********************************************************************
// gsm tile, one ingress group
// header decode, multicast write, shared cell memory split into queues
//********************************************************************
`timescale 1ns/1ps
`include "gsm_cfg.svh"

module gsm_tile import gsm_pkg::*; (
	input  logic clk,
	input  logic clr,

	// local ingress ports
	input  logic [`GSM_GSIZE-1:0] i_valid,	// word strobe
	input  logic [`GSM_GSIZE-1:0] i_header,	// word is a header
	input  data_t [`GSM_GSIZE-1:0] i_words,

	// queue side, queue q = local port * nport + egress port
	input  logic [`GSM_GSIZE*`GSM_NPORT-1:0] i_pop,
	output logic [`GSM_GSIZE*`GSM_NPORT-1:0] o_req,	// queue not empty
	output data_t [`GSM_GSIZE*`GSM_NPORT-1:0] o_head	// head cell
);

	localparam int NQ = `GSM_GSIZE * `GSM_NPORT;	// queues in this tile
	localparam int MDEPTH = NQ * `GSM_QDEPTH;	// shared memory cells

	port_state_t state [`GSM_GSIZE];
	port_mask_t mask [`GSM_GSIZE];	// multicast dest mask

	data_t mem [MDEPTH];	// shared cell memory

	qptr_t wptr [NQ];
	qptr_t rptr [NQ];
	qcnt_t cnt [NQ];

	logic [NQ-1:0] wr_en;	// copy accepted into queue
	logic [NQ-1:0] rd_en;	// head removed
	logic [NQ-1:0] full;

	//********************************************************************
	// header decode
	//********************************************************************
	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			for (int lp = 0; lp < `GSM_GSIZE; lp++) begin
				state[lp] <= PORT_IDLE;
				mask[lp] <= '0;
			end
		end else begin
			for (int lp = 0; lp < `GSM_GSIZE; lp++) begin
				if (i_valid[lp] && i_header[lp]) begin
					mask[lp] <= i_words[lp][`GSM_NPORT-1:0];	// low bits are the mask
					// zero mask disarms the port
					if (|i_words[lp][`GSM_NPORT-1:0])
						state[lp] <= PORT_ARMED;
					else
						state[lp] <= PORT_IDLE;
				end
			end
		end
	end

	//********************************************************************
	// multicast write and pop enables
	//********************************************************************
	always_comb begin
		int q;
		for (int lp = 0; lp < `GSM_GSIZE; lp++) begin
			for (int e = 0; e < `GSM_NPORT; e++) begin
				q = lp * `GSM_NPORT + e;
				full[q] = (cnt[q] == qcnt_t'(`GSM_QDEPTH));
				// payload copy per dest bit, full queue drops its copy
				wr_en[q] = i_valid[lp] && !i_header[lp] &&
					(state[lp] == PORT_ARMED) && mask[lp][e] && !full[q];
				rd_en[q] = i_pop[q] && (cnt[q] != '0);	// never pop empty
			end
		end
	end

	// pointers and fill count
	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			for (int q = 0; q < NQ; q++) begin
				wptr[q] <= '0;
				rptr[q] <= '0;
				cnt[q] <= '0;
			end
		end else begin
			for (int q = 0; q < NQ; q++) begin
				if (wr_en[q])
					wptr[q] <= wptr[q] + qptr_t'(1);	// wraps at depth
				if (rd_en[q])
					rptr[q] <= rptr[q] + qptr_t'(1);
				case ({wr_en[q], rd_en[q]})
					2'b10: cnt[q] <= cnt[q] + qcnt_t'(1);
					2'b01: cnt[q] <= cnt[q] - qcnt_t'(1);
					default: cnt[q] <= cnt[q];	// idle or write and pop together
				endcase
			end
		end
	end

	//********************************************************************
	// shared memory, address = queue * depth + pointer
	//********************************************************************
	always_ff @(posedge clk) begin
		for (int q = 0; q < NQ; q++) begin
			if (wr_en[q])
				mem[q*`GSM_QDEPTH + int'(wptr[q])] <= i_words[q / `GSM_NPORT];
		end
	end

	// head cell and request per queue
	always_comb begin
		for (int q = 0; q < NQ; q++) begin
			o_head[q] = mem[q*`GSM_QDEPTH + int'(rptr[q])];
			o_req[q] = (cnt[q] != '0);
		end
	end

endmodule

/* hdl/rr_sch.sv */
//********************************************************************
// round-robin scheduler for one egress port, with stall
//********************************************************************
`timescale 1ns/1ps
`include "gsm_cfg.svh"

module rr_sch import gsm_pkg::*; (
	input  logic clk,
	input  logic clr,
	input  port_mask_t i_req,	// one bit per ingress port
	input  logic i_stall,	// egress back-pressure
	output port_mask_t o_grant	// one-hot or zero
);

	port_idx_t ptr;	// last granted port
	port_idx_t gidx;	// winner of the search
	port_idx_t idx;
	logic found;

	//********************************************************************
	// search from the port after ptr, wrapping
	//********************************************************************
	always_comb begin
		found = 1'b0;
		gidx = ptr;
		idx = ptr;
		for (int k = 1; k <= `GSM_NPORT; k++) begin
			idx = ptr + port_idx_t'(k);	// 2 bit add wraps, k = nport lands on ptr
			if (!found && i_req[idx]) begin
				found = 1'b1;
				gidx = idx;
			end
		end
		o_grant = '0;
		if (found && !i_stall)
			o_grant[gidx] = 1'b1;	// stall forces zero grant
	end

	// pointer follows the grant, holds under stall
	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			ptr <= port_idx_t'(`GSM_NPORT - 1);	// port 0 first after reset
		end else if (|o_grant) begin
			ptr <= gidx;
		end
	end

endmodule

/* hdl/egress_stage.sv */
//********************************************************************
// egress stage
// per port rr scheduler, granted cell select and output register
//********************************************************************
`timescale 1ns/1ps
`include "gsm_cfg.svh"

module egress_stage import gsm_pkg::*; (
	input  logic clk,
	input  logic clr,

	// per egress port, indexed by global ingress port
	input  port_mask_t [`GSM_NPORT-1:0] i_req,
	input  data_t [`GSM_NPORT-1:0][`GSM_NPORT-1:0] i_cells,	// [egress][ingress]
	input  logic [`GSM_NPORT-1:0] i_stall,

	output port_mask_t [`GSM_NPORT-1:0] o_grant,	// back to the queues as pop
	output logic [`GSM_NPORT-1:0] o_valid,
	output data_t [`GSM_NPORT-1:0] o_data
);

	//********************************************************************
	// one scheduler and output register per egress port
	//********************************************************************
	for (genvar e = 0; e < `GSM_NPORT; e++) begin : g_egress

		data_t sel;	// granted cell

		rr_sch u_rr_sch (
			.clk(clk),
			.clr(clr),
			.i_req(i_req[e]),
			.i_stall(i_stall[e]),
			.o_grant(o_grant[e])
		);

		// one-hot and-or select
		always_comb begin
			sel = '0;
			for (int i = 0; i < `GSM_NPORT; i++) begin
				sel = sel | ({`GSM_DWIDTH{o_grant[e][i]}} & i_cells[e][i]);
			end
		end

		// cell captured at the same edge the queue pops
		always_ff @(posedge clk or posedge clr) begin
			if (clr) begin
				o_valid[e] <= 1'b0;
				o_data[e] <= '0;
			end else begin
				o_valid[e] <= |o_grant[e];	// low under stall
				if (|o_grant[e])
					o_data[e] <= sel;	// hold last cell otherwise
			end
		end

	end

endmodule

/* hdl/gsm_sys.sv */
//********************************************************************
// grouped shared memory switch, 4 in 4 out
// serial ingress, two tiles, round-robin egress
//********************************************************************
`timescale 1ns/1ps
`include "gsm_cfg.svh"

module gsm_sys import gsm_pkg::*; (
	input  logic clk,
	input  logic clr,

	// ingress
	input  logic i_ingress_sdata,
	input  logic [`GSM_NPORT-1:0] i_ingress_valid,
	input  logic [`GSM_NPORT-1:0] i_ingress_header,

	// egress
	input  logic [`GSM_NPORT-1:0] i_egress_stall,
	output logic [`GSM_NPORT-1:0] o_egress_valid,
	output data_t [`GSM_NPORT-1:0] o_egress_data
);

	localparam int NQT = `GSM_GSIZE * `GSM_NPORT;	// queues per tile

	data_t [`GSM_NPORT-1:0] ingress_words;

	// tile side, queue = local port * nport + egress
	logic [`GSM_NTILE-1:0][NQT-1:0] tile_req;
	logic [`GSM_NTILE-1:0][NQT-1:0] tile_pop;
	data_t [`GSM_NTILE-1:0][NQT-1:0] tile_head;

	// egress side, [egress][global ingress]
	port_mask_t [`GSM_NPORT-1:0] eg_req;
	port_mask_t [`GSM_NPORT-1:0] eg_grant;
	data_t [`GSM_NPORT-1:0][`GSM_NPORT-1:0] eg_cells;

	//********************************************************************
	// input side
	//********************************************************************
	ingress_deser u_deser (
		.clk(clk),
		.clr(clr),
		.i_sdata(i_ingress_sdata),
		.o_words(ingress_words)
	);

	//********************************************************************
	// processing, one tile per ingress group
	//********************************************************************
	for (genvar t = 0; t < `GSM_NTILE; t++) begin : g_tile
		gsm_tile u_tile (
			.clk(clk),
			.clr(clr),
			.i_valid(i_ingress_valid[t*`GSM_GSIZE +: `GSM_GSIZE]),
			.i_header(i_ingress_header[t*`GSM_GSIZE +: `GSM_GSIZE]),
			.i_words(ingress_words[t*`GSM_GSIZE +: `GSM_GSIZE]),
			.i_pop(tile_pop[t]),
			.o_req(tile_req[t]),
			.o_head(tile_head[t])
		);
	end

	// gather per egress, global ingress = tile * gsize + local port
	always_comb begin
		for (int t = 0; t < `GSM_NTILE; t++)
			for (int lp = 0; lp < `GSM_GSIZE; lp++)
				for (int e = 0; e < `GSM_NPORT; e++) begin
					eg_req[e][t*`GSM_GSIZE + lp] = tile_req[t][lp*`GSM_NPORT + e];
					eg_cells[e][t*`GSM_GSIZE + lp] = tile_head[t][lp*`GSM_NPORT + e];
				end
	end

	// scatter grants back as pops
	always_comb begin
		for (int t = 0; t < `GSM_NTILE; t++)
			for (int lp = 0; lp < `GSM_GSIZE; lp++)
				for (int e = 0; e < `GSM_NPORT; e++)
					tile_pop[t][lp*`GSM_NPORT + e] = eg_grant[e][t*`GSM_GSIZE + lp];
	end

	//********************************************************************
	// output side
	//********************************************************************
	egress_stage u_egress (
		.clk(clk),
		.clr(clr),
		.i_req(eg_req),
		.i_cells(eg_cells),
		.i_stall(i_egress_stall),
		.o_grant(eg_grant),
		.o_valid(o_egress_valid),
		.o_data(o_egress_data)
	);

endmodule

/* testbench/gsm_sys_tb.sv */
//********************************************************************
// gsm switch testbench
// table driven stimulus checked against a multicast scoreboard
//********************************************************************
`timescale 1ns/1ps
`include "gsm_cfg.svh"

module gsm_sys_tb import gsm_pkg::*; ();

	localparam int PERIOD = 20;
	localparam int HALF = PERIOD / 2;
	localparam int NP = `GSM_NPORT;
	localparam int DW = `GSM_DWIDTH;
	localparam int QD = `GSM_QDEPTH;
	localparam int NENT = 31;
	localparam int DRAIN_CYC = 40;	// bound on one drain wait

	typedef struct packed {
		port_idx_t port;	// ingress port
		logic hdr;	// header strobe
		logic lcg;	// payload from the lcg
		data_t word;	// header word
		port_mask_t stall;	// egress stall while this entry runs
		logic drain;	// wait for empty queues afterwards
	} entry_t;

	//********************************************************************
	// stimulus table columns in order port hdr lcg word stall drain
	//********************************************************************
	localparam entry_t TBL [NENT] = '{
		'{2'd2, 1'b0, 1'b1, 8'h00, 4'b0000, 1'b0},	// payload before any header
		'{2'd3, 1'b0, 1'b1, 8'h00, 4'b0000, 1'b0},
		'{2'd0, 1'b1, 1'b0, 8'h52, 4'b0000, 1'b0},	// unicast from port 0 to egress 1
		'{2'd0, 1'b0, 1'b1, 8'h00, 4'b0000, 1'b0},
		'{2'd0, 1'b0, 1'b1, 8'h00, 4'b0000, 1'b0},
		'{2'd0, 1'b0, 1'b1, 8'h00, 4'b0000, 1'b0},
		'{2'd1, 1'b1, 1'b0, 8'h3e, 4'b0000, 1'b0},	// multicast to egress 1 2 3
		'{2'd1, 1'b0, 1'b1, 8'h00, 4'b0000, 1'b0},
		'{2'd1, 1'b0, 1'b1, 8'h00, 4'b0000, 1'b0},
		'{2'd0, 1'b1, 1'b0, 8'h81, 4'b0001, 1'b0},	// rr setup with egress 0 stalled
		'{2'd0, 1'b0, 1'b1, 8'h00, 4'b0001, 1'b0},
		'{2'd1, 1'b1, 1'b0, 8'h01, 4'b0001, 1'b0},
		'{2'd1, 1'b0, 1'b1, 8'h00, 4'b0001, 1'b0},
		'{2'd2, 1'b1, 1'b0, 8'hc1, 4'b0001, 1'b0},
		'{2'd2, 1'b0, 1'b1, 8'h00, 4'b0001, 1'b0},
		'{2'd3, 1'b1, 1'b0, 8'h11, 4'b0001, 1'b0},
		'{2'd3, 1'b0, 1'b1, 8'h00, 4'b0001, 1'b0},
		'{2'd0, 1'b0, 1'b1, 8'h00, 4'b0001, 1'b0},	// second cell from port 0
		'{2'd2, 1'b1, 1'b0, 8'hc1, 4'b0000, 1'b1},	// release and expect 0 1 2 3 0
		'{2'd3, 1'b1, 1'b0, 8'h74, 4'b0100, 1'b0},	// overflow while egress 2 stalled
		'{2'd3, 1'b0, 1'b1, 8'h00, 4'b0100, 1'b0},
		'{2'd3, 1'b0, 1'b1, 8'h00, 4'b0100, 1'b0},
		'{2'd3, 1'b0, 1'b1, 8'h00, 4'b0100, 1'b0},
		'{2'd3, 1'b0, 1'b1, 8'h00, 4'b0100, 1'b0},
		'{2'd3, 1'b0, 1'b1, 8'h00, 4'b0100, 1'b0},	// queue full so this one drops
		'{2'd3, 1'b0, 1'b1, 8'h00, 4'b0100, 1'b0},	// dropped
		'{2'd3, 1'b1, 1'b0, 8'h74, 4'b0000, 1'b1},	// release egress 2
		'{2'd1, 1'b1, 1'b0, 8'hf0, 4'b0000, 1'b0},	// zero mask disarms port 1
		'{2'd1, 1'b0, 1'b1, 8'h00, 4'b0000, 1'b0},
		'{2'd1, 1'b1, 1'b0, 8'h08, 4'b0000, 1'b0},	// rearm to egress 3
		'{2'd1, 1'b0, 1'b1, 8'h00, 4'b0000, 1'b1}
	};

	logic clk = 1'b0;
	logic clr;
	logic i_ingress_sdata;
	logic [NP-1:0] i_ingress_valid;
	logic [NP-1:0] i_ingress_header;
	logic [NP-1:0] i_egress_stall;
	logic [NP-1:0] o_egress_valid;
	data_t [NP-1:0] o_egress_data;

	// scoreboard with one expected queue per ingress / egress pair
	port_mask_t mask_m [NP];	// dest mask per ingress port
	data_t exp_cell [NP][NP][QD];	// ingress egress slot with slot 0 at the head
	time exp_time [NP][NP][QD];	// accept edge
	logic exp_fast [NP][NP][QD];	// uncontended so latency is fixed
	int exp_cnt [NP][NP];
	port_idx_t rr_ptr [NP];	// last source per egress
	logic [NP-1:0] stall_seen;	// stall during the previous cycle
	logic [31:0] lcg_state;

	int n_data;
	int n_order;
	int n_valid;
	int n_lat;
	int n_other;

	gsm_sys i_dut (
		.clk(clk),
		.clr(clr),
		.i_ingress_sdata(i_ingress_sdata),
		.i_ingress_valid(i_ingress_valid),
		.i_ingress_header(i_ingress_header),
		.i_egress_stall(i_egress_stall),
		.o_egress_valid(o_egress_valid),
		.o_egress_data(o_egress_data)
	);

	initial begin
		forever #HALF clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	//********************************************************************
	// compare tasks
	//********************************************************************
	task automatic check_data(data_t act, data_t exp, int e);
		if (act !== exp) begin
			n_data++;
			$display("CHECK FAILED at %0t: egress %0d cell %h, expected %h",
				$time, e, act, exp);
		end
	endtask

	task automatic check_grant_src(port_idx_t act, port_idx_t exp, int e);
		if (act !== exp) begin
			n_order++;
			$display("CHECK FAILED at %0t: egress %0d served port %0d, rr order gives %0d",
				$time, e, act, exp);
		end
	endtask

	task automatic check_valid(logic [NP-1:0] act, logic [NP-1:0] exp, string what);
		if (act !== exp) begin
			n_valid++;
			$display("CHECK FAILED at %0t: %s, valid %b expected %b",
				$time, what, act, exp);
		end
	endtask

	task automatic check_latency(int act, int exp, int e);
		if (act != exp) begin
			n_lat++;
			$display("CHECK FAILED at %0t: egress %0d latency %0d cycles, expected %0d",
				$time, e, act, exp);
		end
	endtask

	// next source after the last one served that has a cell waiting
	function automatic port_idx_t predict_src(int e);
		port_idx_t p;
		for (int k = 1; k <= NP; k++) begin
			p = rr_ptr[e] + port_idx_t'(k);
			if (exp_cnt[p][e] > 0)
				return p;
		end
		return rr_ptr[e];
	endfunction

	function automatic int count_left();
		int n;
		n = 0;
		for (int s = 0; s < NP; s++)
			for (int e = 0; e < NP; e++)
				n += exp_cnt[s][e];
		return n;
	endfunction

	//********************************************************************
	// scoreboard update on accept and on delivery
	//********************************************************************
	task automatic model_accept(entry_t en, data_t w);
		int busy;
		if (en.hdr) begin
			mask_m[en.port] = w[NP-1:0];	// zero mask means idle
		end else begin
			for (int e = 0; e < NP; e++) begin
				busy = 0;
				for (int s = 0; s < NP; s++)
					busy += exp_cnt[s][e];
				// copy per dest bit unless that queue is full
				if (mask_m[en.port][e] && exp_cnt[en.port][e] < QD) begin
					exp_cell[en.port][e][exp_cnt[en.port][e]] = w;
					exp_time[en.port][e][exp_cnt[en.port][e]] = $time;
					exp_fast[en.port][e][exp_cnt[en.port][e]] =
						!en.stall[e] && busy == 0;
					exp_cnt[en.port][e]++;
				end
			end
		end
	endtask

	task automatic deliver_cell(int e, data_t d);
		port_idx_t src;
		int lat;
		src = d[DW-1 -: 2];	// payload names its source
		if (exp_cnt[src][e] == 0) begin
			n_other++;
			$display("egress %0d delivered cell %h at %0t with nothing queued from port %0d",
				e, d, $time, src);
		end else begin
			check_grant_src(src, predict_src(e), e);
			rr_ptr[e] = src;
			check_data(d, exp_cell[src][e][0], e);
			if (exp_fast[src][e][0]) begin
				lat = int'(($time - exp_time[src][e][0] - HALF) / PERIOD);
				check_latency(lat, 1, e);	// one cycle after accept
			end
			for (int k = 0; k < QD - 1; k++) begin
				exp_cell[src][e][k] = exp_cell[src][e][k+1];
				exp_time[src][e][k] = exp_time[src][e][k+1];
				exp_fast[src][e][k] = exp_fast[src][e][k+1];
			end
			exp_cnt[src][e]--;
		end
	endtask

	// egress monitor samples on the falling edge
	always @(negedge clk) begin
		if (clr) begin
			check_valid(o_egress_valid, '0, "valid during reset");
		end else begin
			check_valid(o_egress_valid & stall_seen, '0, "valid on a stalled egress");
			for (int e = 0; e < NP; e++)
				if (o_egress_valid[e])
					deliver_cell(e, o_egress_data[e]);
		end
		stall_seen = i_egress_stall;
	end

	//********************************************************************
	// driving
	//********************************************************************
	task automatic wait_drain(string where);
		int n;
		int left;
		n = 0;
		left = count_left();
		while (left > 0 && n < DRAIN_CYC) begin
			@(posedge clk);
			n++;
			left = count_left();
		end
		if (left > 0) begin
			n_other++;
			$display("%0d queued cells were not delivered within %0d cycles (%s) at %0t",
				left, DRAIN_CYC, where, $time);
		end
	endtask

	// shift 32 bits msb port first and then strobe for one cycle
	task automatic apply_entry(entry_t en);
		data_t w;
		logic [31:0] rnd;
		logic [NP*DW-1:0] sv;
		w = en.word;
		if (en.lcg) begin
			rnd = lcg_next();
			w = {en.port, rnd[29:24]};	// top 2 bits carry the source
		end
		sv = '0;
		sv[int'(en.port)*DW +: DW] = w;
		for (int b = NP*DW - 1; b >= 0; b--) begin
			@(posedge clk);
			i_ingress_sdata <= sv[b];
			if (b == NP*DW - 1)
				i_egress_stall <= en.stall;
		end
		@(posedge clk);
		i_ingress_sdata <= 1'b0;
		i_ingress_valid[en.port] <= 1'b1;
		i_ingress_header[en.port] <= en.hdr;
		@(posedge clk);	// accept edge
		i_ingress_valid <= '0;
		i_ingress_header <= '0;
		model_accept(en, w);
		if (en.drain)
			wait_drain("drain entry");
	endtask

	task automatic report_counts();
		$display("errors: data %0d, order %0d, valid %0d, latency %0d, other %0d",
			n_data, n_order, n_valid, n_lat, n_other);
	endtask

	initial begin
		clr = 1'b1;
		i_ingress_sdata = 1'b0;
		i_ingress_valid = '0;
		i_ingress_header = '0;
		i_egress_stall = '0;
		stall_seen = '0;
		lcg_state = 32'ha264d906;
		n_data = 0;
		n_order = 0;
		n_valid = 0;
		n_lat = 0;
		n_other = 0;
		for (int p = 0; p < NP; p++) begin
			mask_m[p] = '0;
			rr_ptr[p] = port_idx_t'(NP - 1);	// port 0 first
			for (int e = 0; e < NP; e++)
				exp_cnt[p][e] = 0;
		end
		repeat (8) @(posedge clk);
		clr <= 1'b0;
		for (int i = 0; i < NENT; i++)
			apply_entry(TBL[i]);
		wait_drain("end of table");
		repeat (4) @(posedge clk);	// quiet tail where stray cells still get flagged
		report_counts();
		if (n_data + n_order + n_valid + n_lat + n_other == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// watchdog sized from the table
	initial begin
		int ndrain;
		ndrain = 0;
		for (int i = 0; i < NENT; i++)
			if (TBL[i].drain)
				ndrain++;
		#((NENT * 40 + (ndrain + 1) * DRAIN_CYC + 28) * PERIOD);
		$display("watchdog expired at %0t before the table finished", $time);
		report_counts();
		$display("Some tests failed");
		$finish;
	end

endmodule

/* gsm_sys.f */
+incdir+include
hdl/gsm_pkg.sv
hdl/ingress_deser.sv
hdl/gsm_tile.sv
hdl/rr_sch.sv
hdl/egress_stage.sv
hdl/gsm_sys.sv
testbench/gsm_sys_tb.sv
